//--- apb_gpio.sv
// GPIO unit with rising-edge interrupts only, where writes to GPIO_IN and GPIO_INT_STATUS are ignored
`timescale 1ns/1ns

module apb_gpio (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  soc_periph_apb_pkg::reg_req_t  req_i,
    output soc_periph_apb_pkg::apb_data_t rdata_o,
    output logic                          err_o,
    input  soc_periph_apb_pkg::gpio_t     gpio_in_i,
    output soc_periph_apb_pkg::gpio_t     gpio_out_o,
    output soc_periph_apb_pkg::gpio_t     gpio_dir_o,
    output logic                          gpio_evt_o
);
    import soc_periph_apb_pkg::*;
    import soc_periph_evt_pkg::*;

    gpio_t [SYNC_STAGES-1:0] sync_q;
    gpio_t                   in_q;
    gpio_t                   out_q;
    gpio_t                   dir_q;
    gpio_t                   int_en_q;
    gpio_t                   status_q;
    gpio_t                   rise;
    logic                    evt_q;
    logic                    status_rd;

    //////////////////////////////////////////////////////////////////////
    // Input path and edge detection
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sync_q <= '0;
            in_q   <= '0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], gpio_in_i};
            in_q   <= sync_q[SYNC_STAGES-1];
        end
    end

    // High for the single cycle before in_q catches up
    assign rise      = sync_q[SYNC_STAGES-1] & ~in_q & int_en_q;
    assign status_rd = req_i.rd_en && (req_i.off == GPIO_INT_STATUS);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            status_q <= '0;
            evt_q    <= 1'b0;
        end else begin
            // A new edge wins over a clear in the same cycle
            status_q <= (status_rd ? '0 : status_q) | rise;
            evt_q    <= |rise;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Register file
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            out_q    <= '0;
            dir_q    <= '0;
            int_en_q <= '0;
        end else if (req_i.wr_en) begin
            case (req_i.off)
                GPIO_OUT:    out_q    <= req_i.wdata;
                GPIO_DIR:    dir_q    <= req_i.wdata;
                GPIO_INT_EN: int_en_q <= req_i.wdata;
                default:     ;
            endcase
        end
    end

    always_comb begin
        rdata_o = '0;
        err_o   = 1'b0;
        case (req_i.off)
            GPIO_OUT:        rdata_o = out_q;
            GPIO_DIR:        rdata_o = dir_q;
            GPIO_IN:         rdata_o = in_q;
            GPIO_INT_EN:     rdata_o = int_en_q;
            GPIO_INT_STATUS: rdata_o = status_q;
            default:         err_o   = 1'b1;
        endcase
    end

    assign gpio_out_o = out_q;
    assign gpio_dir_o = dir_q;
    assign gpio_evt_o = evt_q;

endmodule

//--- apb_periph_decoder.sv
// Zero-wait APB slave that accepts an access cycle only right after a setup cycle
`timescale 1ns/1ns

module apb_periph_decoder (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  soc_periph_apb_pkg::apb_req_t  apb_req_i,
    output soc_periph_apb_pkg::apb_rsp_t  apb_rsp_o,
    output soc_periph_apb_pkg::reg_req_t  gpio_req_o,
    input  soc_periph_apb_pkg::apb_data_t gpio_rdata_i,
    input  logic                          gpio_err_i,
    output soc_periph_apb_pkg::reg_req_t  ctrl_req_o,
    input  soc_periph_apb_pkg::apb_data_t ctrl_rdata_i,
    input  logic                          ctrl_err_i
);
    import soc_periph_apb_pkg::*;

    typedef enum logic [1:0] {IDLE, SETUP, ACCESS} phase_e;

    phase_e     phase_q;
    phase_e     phase_d;
    logic [3:0] region;
    logic       in_window;
    logic       sel_gpio;
    logic       sel_ctrl;
    logic       access;
    reg_req_t   base_req;

    // Phase of the current cycle, judged against the previous one
    always_comb begin
        phase_d = IDLE;
        if (apb_req_i.psel && !apb_req_i.penable) begin
            phase_d = SETUP;
        end else if (apb_req_i.psel && apb_req_i.penable && phase_q == SETUP) begin
            phase_d = ACCESS;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            phase_q <= IDLE;
        end else begin
            phase_q <= phase_d;
        end
    end

    assign access    = (phase_d == ACCESS);
    assign region    = apb_req_i.paddr[15:12];
    // Bits 11..5 must be clear, nothing lives above offset 0x1C
    assign in_window = (apb_req_i.paddr[11:5] == '0);
    assign sel_gpio  = in_window && (region == REGION_GPIO);
    assign sel_ctrl  = in_window && (region == REGION_SOC_CTRL);

    //////////////////////////////////////////////////////////////////////
    // Strobes toward the selected peripheral
    //////////////////////////////////////////////////////////////////////
    assign base_req = '{wr_en: 1'b0, rd_en: 1'b0,
                        off: apb_req_i.paddr[4:0], wdata: apb_req_i.pwdata};

    always_comb begin
        gpio_req_o       = base_req;
        ctrl_req_o       = base_req;
        gpio_req_o.wr_en = access && sel_gpio && apb_req_i.pwrite;
        gpio_req_o.rd_en = access && sel_gpio && !apb_req_i.pwrite;
        ctrl_req_o.wr_en = access && sel_ctrl && apb_req_i.pwrite;
        ctrl_req_o.rd_en = access && sel_ctrl && !apb_req_i.pwrite;
    end

    // Response is valid only in the access cycle
    always_comb begin
        apb_rsp_o        = '0;
        apb_rsp_o.pready = access;
        if (access) begin
            if (sel_gpio) begin
                apb_rsp_o.prdata  = gpio_rdata_i;
                apb_rsp_o.pslverr = gpio_err_i;
            end else if (sel_ctrl) begin
                apb_rsp_o.prdata  = ctrl_rdata_i;
                apb_rsp_o.pslverr = ctrl_err_i;
            end else begin
                apb_rsp_o.pslverr = 1'b1;
            end
        end
    end

endmodule

//--- apb_soc_ctrl.sv
// SoC control registers where CTRL_JTAG reads the external input and CTRL_INFO is read-only
`timescale 1ns/1ns

module apb_soc_ctrl (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  soc_periph_apb_pkg::reg_req_t  req_i,
    output soc_periph_apb_pkg::apb_data_t rdata_o,
    output logic                          err_o,
    output soc_periph_apb_pkg::apb_data_t fc_bootaddr_o,
    output logic                          fc_fetchen_o,
    input  soc_periph_apb_pkg::jtag_reg_t soc_jtag_reg_i,
    output soc_periph_apb_pkg::jtag_reg_t soc_jtag_reg_o
);
    import soc_periph_apb_pkg::*;

    apb_data_t bootaddr_q;
    logic      fetchen_q;
    jtag_reg_t jtag_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            bootaddr_q <= BOOT_ADDR_DEFAULT;
            fetchen_q  <= 1'b0;
            jtag_q     <= '0;
        end else if (req_i.wr_en) begin
            case (req_i.off)
                CTRL_BOOTADDR: bootaddr_q <= req_i.wdata;
                CTRL_FETCHEN:  fetchen_q  <= req_i.wdata[0];
                CTRL_JTAG:     jtag_q     <= req_i.wdata[7:0];
                default:       ;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read path
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        rdata_o = '0;
        err_o   = 1'b0;
        case (req_i.off)
            CTRL_BOOTADDR: rdata_o      = bootaddr_q;
            CTRL_FETCHEN:  rdata_o[0]   = fetchen_q;
            // The debugger side of the exchange, not our own write
            CTRL_JTAG:     rdata_o[7:0] = soc_jtag_reg_i;
            CTRL_INFO:     rdata_o      = {NB_CORES[15:0], NGPIO[15:0]};
            default:       err_o        = 1'b1;
        endcase
    end

    assign fc_bootaddr_o  = bootaddr_q;
    assign fc_fetchen_o   = fetchen_q;
    assign soc_jtag_reg_o = jtag_q;

endmodule

//--- compile.f
soc_periph_apb_pkg.sv
soc_periph_evt_pkg.sv
apb_periph_decoder.sv
apb_gpio.sv
apb_soc_ctrl.sv
fc_event_map.sv
soc_peripherals.sv
soc_peripherals_sva.sv
tb_soc_peripherals.sv

//--- fc_event_map.sv
// Event inputs other than slow_clk_i are taken as already synchronous to clk_i
`timescale 1ns/1ns

module fc_event_map (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           slow_clk_i,
    input  logic                           dma_pe_evt_i,
    input  logic                           dma_pe_irq_i,
    input  logic                           pf_evt_i,
    input  logic                           gpio_evt_i,
    output soc_periph_evt_pkg::fc_events_t fc_events_o
);
    import soc_periph_evt_pkg::*;

    // Synchronizer flops plus one more to hold the previous level
    logic [SYNC_STAGES:0] ref_q;
    logic                 ref_edge;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ref_q <= '0;
        end else begin
            ref_q <= {ref_q[SYNC_STAGES-1:0], slow_clk_i};
        end
    end

    // Rising and falling edge merged
    assign ref_edge = ref_q[SYNC_STAGES] ^ ref_q[SYNC_STAGES-1];

    //////////////////////////////////////////////////////////////////////
    // Vector assembly
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        fc_events_o               = '0;
        fc_events_o[EVT_DMA_PE]   = dma_pe_evt_i;
        fc_events_o[EVT_DMA_IRQ]  = dma_pe_irq_i;
        fc_events_o[EVT_PF]       = pf_evt_i;
        fc_events_o[EVT_REF_EDGE] = ref_edge;
        fc_events_o[EVT_GPIO]     = gpio_evt_i;
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide the result from the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_soc_peripherals \
    -f compile.f -o tb_sim > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "Simulator returned an error status"
grep -qx "TESTS PASSED" sim.log \
    && echo "Simulation passed" \
    || { cat sim.log; echo "Simulation failed"; exit 1; }

//--- soc_periph_apb_pkg.sv
// Fixed 32-bit APB with the peripheral region in paddr[15:12] and only word offsets below 0x20
package soc_periph_apb_pkg;

    //////////////////////////////////////////////////////////////////////
    // Bus types
    //////////////////////////////////////////////////////////////////////
    typedef logic [31:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    typedef struct packed {
        apb_addr_t paddr;
        apb_data_t pwdata;
        logic      pwrite;
        logic      psel;
        logic      penable;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    // One access toward one peripheral
    typedef logic [4:0] reg_off_t;

    typedef struct packed {
        logic      wr_en;
        logic      rd_en;
        reg_off_t  off;
        apb_data_t wdata;
    } reg_req_t;

    //////////////////////////////////////////////////////////////////////
    // Address map
    //////////////////////////////////////////////////////////////////////
    localparam logic [3:0] REGION_GPIO     = 4'd0;
    localparam logic [3:0] REGION_SOC_CTRL = 4'd1;

    localparam reg_off_t GPIO_OUT        = 5'h00;
    localparam reg_off_t GPIO_DIR        = 5'h04;
    localparam reg_off_t GPIO_IN         = 5'h08;
    localparam reg_off_t GPIO_INT_EN     = 5'h0C;
    localparam reg_off_t GPIO_INT_STATUS = 5'h10;

    localparam reg_off_t CTRL_BOOTADDR = 5'h00;
    localparam reg_off_t CTRL_FETCHEN  = 5'h04;
    localparam reg_off_t CTRL_JTAG     = 5'h08;
    localparam reg_off_t CTRL_INFO     = 5'h0C;

    localparam apb_data_t BOOT_ADDR_DEFAULT = 32'h1C00_8080;

    localparam logic [31:0] NGPIO    = 32'd32;
    localparam logic [31:0] NB_CORES = 32'd4;

    typedef logic [NGPIO-1:0] gpio_t;
    typedef logic [7:0]       jtag_reg_t;

endpackage

//--- soc_periph_evt_pkg.sv
// Fabric-controller event layout with bits 8, 9, 12, 14 and 15 in use and the rest reserved
package soc_periph_evt_pkg;

    //////////////////////////////////////////////////////////////////////
    // Event vector
    //////////////////////////////////////////////////////////////////////
    typedef logic [31:0] fc_events_t;

    // Bits 7..0 stay free for software events
    localparam int unsigned EVT_DMA_PE   = 8;
    localparam int unsigned EVT_DMA_IRQ  = 9;
    localparam int unsigned EVT_PF       = 12;

    // Both edges of the slow reference clock share one bit
    localparam int unsigned EVT_REF_EDGE = 14;
    localparam int unsigned EVT_GPIO     = 15;

    //////////////////////////////////////////////////////////////////////
    // Synchronizers
    //////////////////////////////////////////////////////////////////////
    // Flop count for any input crossing into clk_i, at least 2
    localparam int unsigned SYNC_STAGES = 2;

endpackage

//--- soc_peripherals.sv
// APB peripheral block with GPIO at region 0 and SoC control at region 1, address bits above 15 ignored
`timescale 1ns/1ns

module soc_peripherals (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  soc_periph_apb_pkg::apb_req_t   apb_req_i,
    output soc_periph_apb_pkg::apb_rsp_t   apb_rsp_o,
    input  soc_periph_apb_pkg::gpio_t      gpio_in_i,
    output soc_periph_apb_pkg::gpio_t      gpio_out_o,
    output soc_periph_apb_pkg::gpio_t      gpio_dir_o,
    output soc_periph_apb_pkg::apb_data_t  fc_bootaddr_o,
    output logic                           fc_fetchen_o,
    input  soc_periph_apb_pkg::jtag_reg_t  soc_jtag_reg_i,
    output soc_periph_apb_pkg::jtag_reg_t  soc_jtag_reg_o,
    input  logic                           slow_clk_i,
    input  logic                           dma_pe_evt_i,
    input  logic                           dma_pe_irq_i,
    input  logic                           pf_evt_i,
    output soc_periph_evt_pkg::fc_events_t fc_events_o
);
    import soc_periph_apb_pkg::*;

    reg_req_t  gpio_req;
    reg_req_t  ctrl_req;
    apb_data_t gpio_rdata;
    apb_data_t ctrl_rdata;
    logic      gpio_err;
    logic      ctrl_err;
    logic      gpio_evt;

    //////////////////////////////////////////////////////////////////////
    // Bus decode
    //////////////////////////////////////////////////////////////////////
    apb_periph_decoder i_decoder (
        .clk_i        ( clk_i      ),
        .rst_i        ( rst_i      ),
        .apb_req_i    ( apb_req_i  ),
        .apb_rsp_o    ( apb_rsp_o  ),
        .gpio_req_o   ( gpio_req   ),
        .gpio_rdata_i ( gpio_rdata ),
        .gpio_err_i   ( gpio_err   ),
        .ctrl_req_o   ( ctrl_req   ),
        .ctrl_rdata_i ( ctrl_rdata ),
        .ctrl_err_i   ( ctrl_err   )
    );

    //////////////////////////////////////////////////////////////////////
    // Peripherals
    //////////////////////////////////////////////////////////////////////
    apb_gpio i_gpio (
        .clk_i      ( clk_i      ),
        .rst_i      ( rst_i      ),
        .req_i      ( gpio_req   ),
        .rdata_o    ( gpio_rdata ),
        .err_o      ( gpio_err   ),
        .gpio_in_i  ( gpio_in_i  ),
        .gpio_out_o ( gpio_out_o ),
        .gpio_dir_o ( gpio_dir_o ),
        .gpio_evt_o ( gpio_evt   )
    );

    apb_soc_ctrl i_soc_ctrl (
        .clk_i          ( clk_i          ),
        .rst_i          ( rst_i          ),
        .req_i          ( ctrl_req       ),
        .rdata_o        ( ctrl_rdata     ),
        .err_o          ( ctrl_err       ),
        .fc_bootaddr_o  ( fc_bootaddr_o  ),
        .fc_fetchen_o   ( fc_fetchen_o   ),
        .soc_jtag_reg_i ( soc_jtag_reg_i ),
        .soc_jtag_reg_o ( soc_jtag_reg_o )
    );

    // GPIO interrupt joins the external events here
    fc_event_map i_event_map (
        .clk_i        ( clk_i        ),
        .rst_i        ( rst_i        ),
        .slow_clk_i   ( slow_clk_i   ),
        .dma_pe_evt_i ( dma_pe_evt_i ),
        .dma_pe_irq_i ( dma_pe_irq_i ),
        .pf_evt_i     ( pf_evt_i     ),
        .gpio_evt_i   ( gpio_evt     ),
        .fc_events_o  ( fc_events_o  )
    );

endmodule

//--- soc_peripherals_sva.sv
// Watches only the top-level APB and event ports, rules hold outside reset
`timescale 1ns/1ns

module soc_peripherals_sva (
    input logic                           clk_i,
    input logic                           rst_i,
    input soc_periph_apb_pkg::apb_req_t   apb_req_i,
    input soc_periph_apb_pkg::apb_rsp_t   apb_rsp_i,
    input soc_periph_evt_pkg::fc_events_t fc_events_i
);
    import soc_periph_evt_pkg::*;

    localparam fc_events_t USED_MASK = (fc_events_t'(1) << EVT_DMA_PE)
                                     | (fc_events_t'(1) << EVT_DMA_IRQ)
                                     | (fc_events_t'(1) << EVT_PF)
                                     | (fc_events_t'(1) << EVT_REF_EDGE)
                                     | (fc_events_t'(1) << EVT_GPIO);

    //////////////////////////////////////////////////////////////////////
    // APB response
    //////////////////////////////////////////////////////////////////////
    // Access cycle means the previous cycle was a setup cycle
    pready_in_access: assert property (@(posedge clk_i) disable iff (rst_i)
        apb_rsp_i.pready |-> (apb_req_i.psel && apb_req_i.penable
                              && $past(apb_req_i.psel && !apb_req_i.penable)))
        else $error("pready raised outside an APB access cycle");

    pslverr_with_pready: assert property (@(posedge clk_i) disable iff (rst_i)
        apb_rsp_i.pslverr |-> apb_rsp_i.pready)
        else $error("pslverr raised without pready");

    // Reserved event bits
    reserved_events_zero: assert property (@(posedge clk_i) disable iff (rst_i)
        (fc_events_i & ~USED_MASK) == '0)
        else $error("reserved fc_events_o bit set");

endmodule

bind soc_peripherals soc_peripherals_sva u_sva (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .apb_req_i   ( apb_req_i   ),
    .apb_rsp_i   ( apb_rsp_o   ),
    .fc_events_i ( fc_events_o )
);

//--- tb_soc_peripherals.sv
// Testbench for the APB peripheral block, assumes zero-wait APB and slow_clk_i far slower than clk_i
`timescale 1ns/1ns

module tb_soc_peripherals;
    import soc_periph_apb_pkg::*;
    import soc_periph_evt_pkg::*;

    typedef struct packed {
        logic      write;
        apb_addr_t addr;
        apb_data_t wdata;
        apb_data_t rdata;
        logic      err;
    } apb_case_t;

    localparam int        TABLE_LEN   = 16;
    localparam int        EVT_TESTS   = 3;
    localparam int        CYCLE_LIMIT = 2 * TABLE_LEN + 60 * EVT_TESTS + 100;
    localparam int        REF_TOGGLES = 6;
    localparam int        GPIO_PIN    = 5;
    localparam apb_addr_t GPIO_BASE   = 32'h0000_0000;
    localparam apb_addr_t CTRL_BASE   = 32'h0000_1000;
    localparam apb_data_t DIR_WORD    = 32'h0000_F0F3;
    localparam jtag_reg_t JTAG_IN     = 8'h3C;
    // NB_CORES in the upper half, NGPIO in the lower half
    localparam apb_data_t INFO_WORD   = 32'h0004_0020;

    logic       clk_i;
    logic       rst_i;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    gpio_t      gpio_in;
    gpio_t      gpio_out;
    gpio_t      gpio_dir;
    apb_data_t  fc_bootaddr;
    logic       fc_fetchen;
    jtag_reg_t  jtag_in;
    jtag_reg_t  jtag_out;
    logic       slow_clk;
    logic       dma_pe_evt;
    logic       dma_pe_irq;
    logic       pf_evt;
    fc_events_t fc_events;

    apb_case_t  cases [TABLE_LEN];
    apb_data_t  out_word;
    apb_data_t  boot_word;
    logic [31:0] lfsr_q = 32'h8e82b662;
    int         errs [4];
    logic [1:0] cur_group;
    int         cycle_cnt;
    int         gpio_evt_total;
    int         ref_edge_total;

    soc_peripherals DUT (
        .clk_i          ( clk_i       ),
        .rst_i          ( rst_i       ),
        .apb_req_i      ( apb_req     ),
        .apb_rsp_o      ( apb_rsp     ),
        .gpio_in_i      ( gpio_in     ),
        .gpio_out_o     ( gpio_out    ),
        .gpio_dir_o     ( gpio_dir    ),
        .fc_bootaddr_o  ( fc_bootaddr ),
        .fc_fetchen_o   ( fc_fetchen  ),
        .soc_jtag_reg_i ( jtag_in     ),
        .soc_jtag_reg_o ( jtag_out    ),
        .slow_clk_i     ( slow_clk    ),
        .dma_pe_evt_i   ( dma_pe_evt  ),
        .dma_pe_irq_i   ( dma_pe_irq  ),
        .pf_evt_i       ( pf_evt      ),
        .fc_events_o    ( fc_events   )
    );

    initial clk_i = 1'b0;
    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles, the tests did not finish", cycle_cnt);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // Counts high cycles, so a stretched pulse shows up as extra counts
    always @(negedge clk_i) begin
        if (!rst_i) begin
            if (fc_events[EVT_GPIO]) gpio_evt_total <= gpio_evt_total + 1;
            if (fc_events[EVT_REF_EDGE]) ref_edge_total <= ref_edge_total + 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////
    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            errs[cur_group] += 1;
            $display("ERROR %0t ns %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    // Right-shifting Galois form, one step per output bit
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    task automatic draw_word(output apb_data_t w);
        w = '0;
        for (int b = 0; b < 32; b++) begin
            w = {w[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    function automatic apb_case_t make_case(input logic wr, input apb_addr_t addr,
                                            input apb_data_t wdata, input apb_data_t rdata,
                                            input logic err);
        return '{write: wr, addr: addr, wdata: wdata, rdata: rdata, err: err};
    endfunction

    task automatic fill_table();
        draw_word(out_word);
        draw_word(boot_word);
        cases[0]  = make_case(1'b1, GPIO_BASE | 32'(GPIO_OUT), out_word, '0, 1'b0);
        cases[1]  = make_case(1'b0, GPIO_BASE | 32'(GPIO_OUT), '0, out_word, 1'b0);
        cases[2]  = make_case(1'b1, GPIO_BASE | 32'(GPIO_DIR), DIR_WORD, '0, 1'b0);
        cases[3]  = make_case(1'b0, GPIO_BASE | 32'(GPIO_DIR), '0, DIR_WORD, 1'b0);
        cases[4]  = make_case(1'b1, CTRL_BASE | 32'(CTRL_BOOTADDR), boot_word, '0, 1'b0);
        cases[5]  = make_case(1'b0, CTRL_BASE | 32'(CTRL_BOOTADDR), '0, boot_word, 1'b0);
        cases[6]  = make_case(1'b1, CTRL_BASE | 32'(CTRL_FETCHEN), 32'hFFFF_FFFF, '0, 1'b0);
        cases[7]  = make_case(1'b0, CTRL_BASE | 32'(CTRL_FETCHEN), '0, 32'd1, 1'b0);
        cases[8]  = make_case(1'b1, CTRL_BASE | 32'(CTRL_JTAG), 32'h0000_00A5, '0, 1'b0);
        // Reads the debugger side, not the value just written
        cases[9]  = make_case(1'b0, CTRL_BASE | 32'(CTRL_JTAG), '0, 32'(JTAG_IN), 1'b0);
        cases[10] = make_case(1'b0, CTRL_BASE | 32'(CTRL_INFO), '0, INFO_WORD, 1'b0);
        cases[11] = make_case(1'b0, 32'h0000_2000, '0, '0, 1'b1);
        cases[12] = make_case(1'b1, 32'h0000_2004, 32'hDEAD_BEEF, '0, 1'b1);
        cases[13] = make_case(1'b0, GPIO_BASE | 32'h14, '0, '0, 1'b1);
        cases[14] = make_case(1'b0, CTRL_BASE | 32'h10, '0, '0, 1'b1);
        cases[15] = make_case(1'b0, GPIO_BASE | 32'h40, '0, '0, 1'b1);
    endtask

    // Setup cycle, access cycle, sample before the closing edge
    task automatic apb_transfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                                output apb_data_t rdata, output logic err);
        @(posedge clk_i);
        #2;
        apb_req = '{paddr: addr, pwdata: wdata, pwrite: wr, psel: 1'b1, penable: 1'b0};
        @(posedge clk_i);
        #2;
        apb_req.penable = 1'b1;
        @(negedge clk_i);
        check_value($sformatf("pready[%h]", addr), 32'd1, 32'(apb_rsp.pready));
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
    endtask

    task automatic apb_idle();
        @(posedge clk_i);
        #2;
        apb_req = '0;
    endtask

    task automatic read_expect(input string name, input apb_addr_t addr, input apb_data_t exp);
        apb_data_t rdata;
        logic      err;
        apb_transfer(1'b0, addr, '0, rdata, err);
        check_value({name, " pslverr"}, 32'd0, 32'(err));
        check_value(name, exp, rdata);
    endtask

    task automatic run_table();
        apb_data_t rdata;
        logic      err;
        for (int i = 0; i < TABLE_LEN; i++) begin
            apb_transfer(cases[i].write, cases[i].addr, cases[i].wdata, rdata, err);
            check_value($sformatf("pslverr[%h]", cases[i].addr), 32'(cases[i].err), 32'(err));
            if (!cases[i].write) begin
                check_value($sformatf("prdata[%h]", cases[i].addr), cases[i].rdata, rdata);
            end
        end
        apb_idle();
    endtask

    task automatic drive_events(input logic pe, input logic irq, input logic pf);
        fc_events_t exp;
        @(posedge clk_i);
        #2;
        dma_pe_evt = pe;
        dma_pe_irq = irq;
        pf_evt     = pf;
        exp = '0;
        exp[EVT_DMA_PE]  = pe;
        exp[EVT_DMA_IRQ] = irq;
        exp[EVT_PF]      = pf;
        @(negedge clk_i);
        check_value("fc_events_o", exp, fc_events);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        int        total;
        int        start;
        apb_data_t rdata;
        logic      err;
        rst_i      = 1'b1;
        apb_req    = '0;
        gpio_in    = '0;
        jtag_in    = JTAG_IN;
        slow_clk   = 1'b0;
        dma_pe_evt = 1'b0;
        dma_pe_irq = 1'b0;
        pf_evt     = 1'b0;
        cur_group  = 2'd0;
        fill_table();
        repeat (2) @(posedge clk_i);
        #2;
        rst_i = 1'b0;

        @(negedge clk_i);
        check_value("fc_bootaddr_o", BOOT_ADDR_DEFAULT, fc_bootaddr);
        check_value("fc_fetchen_o", 32'd0, 32'(fc_fetchen));
        check_value("gpio_out_o", 32'd0, gpio_out);
        check_value("gpio_dir_o", 32'd0, gpio_dir);
        check_value("soc_jtag_reg_o", 32'd0, 32'(jtag_out));
        check_value("fc_events_o", 32'd0, fc_events);
        check_value("pready", 32'd0, 32'(apb_rsp.pready));
        check_value("pslverr", 32'd0, 32'(apb_rsp.pslverr));

        cur_group = 2'd1;
        run_table();
        check_value("gpio_out_o", out_word, gpio_out);
        check_value("gpio_dir_o", DIR_WORD, gpio_dir);
        check_value("fc_bootaddr_o", boot_word, fc_bootaddr);
        check_value("fc_fetchen_o", 32'd1, 32'(fc_fetchen));
        check_value("soc_jtag_reg_o", 32'h0000_00A5, 32'(jtag_out));

        // Rising edge on one enabled pin
        cur_group = 2'd2;
        apb_transfer(1'b1, GPIO_BASE | 32'(GPIO_INT_EN), gpio_t'(1) << GPIO_PIN, rdata, err);
        apb_idle();
        start = gpio_evt_total;
        @(posedge clk_i);
        #2;
        gpio_in = gpio_t'(1) << GPIO_PIN;
        repeat (5) @(posedge clk_i);
        read_expect("GPIO_IN", GPIO_BASE | 32'(GPIO_IN), gpio_t'(1) << GPIO_PIN);
        read_expect("GPIO_INT_STATUS", GPIO_BASE | 32'(GPIO_INT_STATUS), gpio_t'(1) << GPIO_PIN);
        read_expect("GPIO_INT_STATUS", GPIO_BASE | 32'(GPIO_INT_STATUS), '0);
        apb_idle();
        check_value("EVT_GPIO pulse count", 32'd1, 32'(gpio_evt_total - start));

        cur_group = 2'd3;
        drive_events(1'b1, 1'b0, 1'b0);
        drive_events(1'b0, 1'b1, 1'b0);
        drive_events(1'b0, 1'b0, 1'b1);
        drive_events(1'b1, 1'b1, 1'b1);
        drive_events(1'b0, 1'b0, 1'b0);

        start = ref_edge_total;
        for (int k = 0; k < REF_TOGGLES; k++) begin
            @(posedge clk_i);
            #2;
            slow_clk = ~slow_clk;
            repeat (7) @(posedge clk_i);
        end
        repeat (8) @(posedge clk_i);
        check_value("EVT_REF_EDGE pulse count", 32'(REF_TOGGLES), 32'(ref_edge_total - start));

        total = errs[0] + errs[1] + errs[2] + errs[3];
        $display("Error counts: reset %0d, apb %0d, gpio %0d, events %0d",
                 errs[0], errs[1], errs[2], errs[3]);
        if (total == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
